// ==== dcache_pkg.sv ====
package dcache_pkg;

    // Line geometry
    localparam int BLOCK_BYTES = 8;
    localparam int OFFSET_BITS = $clog2(BLOCK_BYTES);
    localparam int TAG_BITS = 32 - OFFSET_BITS;

    // Cache and tracker sizes
    localparam int NUM_LINES = 4;
    localparam int LINE_INDEX_BITS = $clog2(NUM_LINES);
    localparam int MSHR_DEPTH = 4;
    localparam int MSHR_INDEX_BITS = $clog2(MSHR_DEPTH);

    localparam int READ_PORTS = 2;
    // Tag zero is reserved for "no tag"
    localparam int MEM_TAG_BITS = 4;

    // Victim selection LFSR
    localparam int LFSR_BITS = 8;
    localparam logic [LFSR_BITS-1:0] LFSR_SEED = 8'h01;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [TAG_BITS-1:0] line_tag_t;
    typedef logic [8*BLOCK_BYTES-1:0] block_t;
    typedef logic [BLOCK_BYTES-1:0] byte_en_t;
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;
    typedef logic [LINE_INDEX_BITS-1:0] line_index_t;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    // Load address, read request and refill notice
    typedef struct packed {
        logic valid;
        line_tag_t tag;
    } line_req_t;

    typedef struct packed {
        logic valid;
        block_t data;
    } read_result_t;

    typedef struct packed {
        logic valid;
        addr_t addr;
        word_t data;
        mem_size_e size;
    } store_req_t;

    // Store already placed at its byte lanes
    typedef struct packed {
        logic valid;
        line_tag_t tag;
        block_t data;
        byte_en_t byte_en;
    } store_write_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        line_tag_t tag;
        block_t data;
    } cache_line_t;

    typedef struct packed {
        logic valid;
        mem_tag_t mem_tag;
        line_tag_t tag;
    } mshr_entry_t;

    typedef struct packed {
        logic valid;
        line_tag_t tag;
        block_t data;
    } writeback_t;

endpackage

// ==== store_align.sv ====
`timescale 1ns/1ps

module store_align (
    input  dcache_pkg::store_req_t   store_req,
    output dcache_pkg::store_write_t store_write
);

    // Data and enables within one 32-bit word
    dcache_pkg::word_t lane_data;
    logic [3:0] lane_en;
    logic [1:0] byte_offset;
    logic upper_word;

    assign byte_offset = store_req.addr[1:0];
    assign upper_word = store_req.addr[2];

    // Place the value at its byte offset inside the selected word
    always_comb begin
        case (store_req.size)
            dcache_pkg::BYTE: begin
                lane_data = dcache_pkg::word_t'(store_req.data[7:0]) << (8 * byte_offset);
                lane_en = 4'b0001 << byte_offset;
            end
            dcache_pkg::HALF: begin
                // Halfword stays within its aligned half
                lane_data = dcache_pkg::word_t'(store_req.data[15:0]) << (16 * byte_offset[1]);
                lane_en = 4'b0011 << (2 * byte_offset[1]);
            end
            default: begin
                lane_data = store_req.data;
                lane_en = 4'b1111;
            end
        endcase
    end

    // Expand to the full line
    always_comb begin
        store_write.valid = store_req.valid;
        store_write.tag = store_req.addr[31:dcache_pkg::OFFSET_BITS];
        if (upper_word) begin
            store_write.data = {lane_data, 32'h0};
            store_write.byte_en = {lane_en, 4'b0000};
        end else begin
            store_write.data = {32'h0, lane_data};
            store_write.byte_en = {4'b0000, lane_en};
        end
    end

endmodule

// ==== line_store.sv ====
`timescale 1ns/1ps

module line_store (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  dcache_pkg::line_req_t    [dcache_pkg::READ_PORTS-1:0] read_addrs,
    output dcache_pkg::read_result_t [dcache_pkg::READ_PORTS-1:0] cache_outs,
    input  dcache_pkg::store_write_t                             store_write,
    output logic                                                 store_hit,
    output logic                                                 store_done,
    input  dcache_pkg::line_req_t                                refill,
    input  dcache_pkg::block_t                                   refill_data,
    output dcache_pkg::writeback_t                               eviction
);

    dcache_pkg::cache_line_t [dcache_pkg::NUM_LINES-1:0] lines;
    dcache_pkg::cache_line_t write_line;
    logic [dcache_pkg::NUM_LINES-1:0] write_en;

    dcache_pkg::line_index_t hit_index;
    dcache_pkg::line_index_t free_index;
    dcache_pkg::line_index_t victim_index;
    logic free_found;
    logic refill_present;

    logic [dcache_pkg::LFSR_BITS-1:0] lfsr;
    dcache_pkg::block_t merged;

    logic evict_capture;
    logic evict_valid;
    dcache_pkg::line_tag_t evict_tag;
    dcache_pkg::block_t evict_data;

    // Load lookups, both ports in the same cycle
    always_comb begin
        cache_outs = '0;
        for (int p = 0; p < dcache_pkg::READ_PORTS; p++) begin
            for (int i = 0; i < dcache_pkg::NUM_LINES; i++) begin
                if (read_addrs[p].valid && lines[i].valid && lines[i].tag == read_addrs[p].tag) begin
                    cache_outs[p].valid = 1'b1;
                    cache_outs[p].data = lines[i].data;
                end
            end
        end
    end

    // Store tag compare
    always_comb begin
        store_hit = 1'b0;
        hit_index = '0;
        for (int i = 0; i < dcache_pkg::NUM_LINES; i++) begin
            if (store_write.valid && lines[i].valid && lines[i].tag == store_write.tag) begin
                store_hit = 1'b1;
                hit_index = dcache_pkg::line_index_t'(i);
            end
        end
    end

    // Lowest invalid line wins
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = dcache_pkg::NUM_LINES - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                free_found = 1'b1;
                free_index = dcache_pkg::line_index_t'(i);
            end
        end
    end

    // A refilled line must not already be in the array
    always_comb begin
        refill_present = 1'b0;
        for (int i = 0; i < dcache_pkg::NUM_LINES; i++) begin
            if (lines[i].valid && lines[i].tag == refill.tag) begin
                refill_present = 1'b1;
            end
        end
    end

    // NUM_LINES is a power of two, so the low bits index a line directly
    assign victim_index = lfsr[dcache_pkg::LINE_INDEX_BITS-1:0];

    // Taps 8,6,5,4
    always_ff @(posedge clock) begin
        if (!reset) begin
            lfsr <= dcache_pkg::LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // Byte merge of the store into the hit line
    always_comb begin
        merged = lines[hit_index].data;
        for (int b = 0; b < dcache_pkg::BLOCK_BYTES; b++) begin
            if (store_write.byte_en[b]) begin
                merged[8*b +: 8] = store_write.data[8*b +: 8];
            end
        end
    end

    // Write port, refill ahead of store
    always_comb begin
        write_en = '0;
        write_line = '0;
        evict_capture = 1'b0;
        if (refill.valid) begin
            write_line = '{valid: 1'b1, dirty: 1'b0, tag: refill.tag, data: refill_data};
            if (free_found) begin
                write_en[free_index] = 1'b1;
            end else begin
                write_en[victim_index] = 1'b1;
                evict_capture = lines[victim_index].dirty;
            end
        end else if (store_hit) begin
            write_en[hit_index] = 1'b1;
            write_line = '{valid: 1'b1,
                           dirty: lines[hit_index].dirty || (merged != lines[hit_index].data),
                           tag: lines[hit_index].tag,
                           data: merged};
        end
    end

    assign store_done = store_hit && !refill.valid;

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < dcache_pkg::NUM_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < dcache_pkg::NUM_LINES; i++) begin
                if (write_en[i]) begin
                    lines[i] <= write_line;
                end
            end
        end
    end

    // Victim is captured before the refill overwrites it
    always_ff @(posedge clock) begin
        if (!reset) begin
            evict_valid <= 1'b0;
        end else begin
            evict_valid <= evict_capture;
        end
    end

    always_ff @(posedge clock) begin
        if (evict_capture) begin
            evict_tag <= lines[victim_index].tag;
            evict_data <= lines[victim_index].data;
        end
    end

    assign eviction = '{valid: evict_valid, tag: evict_tag, data: evict_data};

    a_refill_absent: assert property (@(posedge clock) disable iff (!reset)
        refill.valid |-> !refill_present);

endmodule

// ==== miss_tracker.sv ====
`timescale 1ns/1ps

module miss_tracker (
    input  logic                    clock,
    input  logic                    reset,
    input  dcache_pkg::line_tag_t   snoop_tag,
    output logic                    dup_found,
    input  dcache_pkg::mshr_entry_t push,
    input  dcache_pkg::mem_tag_t    mem_data_tag,
    output dcache_pkg::line_req_t   refill
);

    dcache_pkg::mshr_entry_t [dcache_pkg::MSHR_DEPTH-1:0] entries;
    logic [dcache_pkg::MSHR_INDEX_BITS-1:0] head;
    logic [dcache_pkg::MSHR_INDEX_BITS-1:0] tail;
    logic [dcache_pkg::MSHR_INDEX_BITS:0] count;
    logic pop;
    logic full;

    assign full = (count == (dcache_pkg::MSHR_INDEX_BITS + 1)'(dcache_pkg::MSHR_DEPTH));

    // Duplicate snoop over every outstanding entry
    always_comb begin
        dup_found = 1'b0;
        for (int i = 0; i < dcache_pkg::MSHR_DEPTH; i++) begin
            if (entries[i].valid && entries[i].tag == snoop_tag) begin
                dup_found = 1'b1;
            end
        end
    end

    // Responses come back in request order
    assign pop = (mem_data_tag != '0) && entries[head].valid
                 && (entries[head].mem_tag == mem_data_tag);

    assign refill = '{valid: pop, tag: entries[head].tag};

    always_ff @(posedge clock) begin
        if (!reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < dcache_pkg::MSHR_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head <= head + 1'b1;
            end
            if (push.valid) begin
                entries[tail] <= push;
                tail <= tail + 1'b1;
            end
            // Push and pop together leave the count unchanged
            if (push.valid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push.valid) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clock) disable iff (!reset)
        push.valid |-> !full);

endmodule

// ==== mem_port_arbiter.sv ====
`timescale 1ns/1ps

module mem_port_arbiter (
    input  dcache_pkg::line_req_t    [dcache_pkg::READ_PORTS-1:0] read_addrs,
    input  dcache_pkg::read_result_t [dcache_pkg::READ_PORTS-1:0] cache_outs,
    input  dcache_pkg::store_req_t                               store_req,
    input  logic                                                 store_hit,
    input  dcache_pkg::writeback_t                               eviction,
    input  logic                                                 dup_found,
    output dcache_pkg::line_tag_t                                snoop_tag,
    output dcache_pkg::line_req_t                                mem_req,
    input  logic                                                 mem_req_accepted,
    input  dcache_pkg::mem_tag_t                                 current_req_tag,
    output dcache_pkg::mshr_entry_t                              push,
    output dcache_pkg::writeback_t                               mem_write
);

    dcache_pkg::line_req_t oldest_miss;

    // Store miss first, then the lowest numbered load port
    always_comb begin
        oldest_miss = '0;
        for (int p = dcache_pkg::READ_PORTS - 1; p >= 0; p--) begin
            if (read_addrs[p].valid && !cache_outs[p].valid) begin
                oldest_miss = read_addrs[p];
            end
        end
        if (store_req.valid && !store_hit) begin
            oldest_miss.valid = 1'b1;
            oldest_miss.tag = store_req.addr[31:dcache_pkg::OFFSET_BITS];
        end
    end

    assign snoop_tag = oldest_miss.tag;

    // Eviction already carries only dirty victims
    assign mem_write = eviction;

    // Writeback owns the port this cycle, the read retries next cycle
    always_comb begin
        mem_req.valid = oldest_miss.valid && !eviction.valid && !dup_found;
        mem_req.tag = oldest_miss.tag;
    end

    // Track the request once memory hands out a real tag
    always_comb begin
        push.valid = mem_req.valid && mem_req_accepted && (current_req_tag != '0);
        push.mem_tag = current_req_tag;
        push.tag = mem_req.tag;
    end

endmodule

// ==== dcache_subsystem.sv ====
`timescale 1ns/1ps

module dcache_subsystem (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  dcache_pkg::line_req_t    [dcache_pkg::READ_PORTS-1:0] read_addrs,
    output dcache_pkg::read_result_t [dcache_pkg::READ_PORTS-1:0] cache_outs,
    input  dcache_pkg::store_req_t                               store_req,
    output logic                                                 store_done,
    output dcache_pkg::line_req_t                                mem_req,
    input  logic                                                 mem_req_accepted,
    input  dcache_pkg::mem_tag_t                                 current_req_tag,
    input  dcache_pkg::block_t                                   mem_data,
    input  dcache_pkg::mem_tag_t                                 mem_data_tag,
    output dcache_pkg::writeback_t                               mem_write
);

    dcache_pkg::store_write_t store_write;
    logic store_hit;
    dcache_pkg::writeback_t eviction;
    logic dup_found;
    dcache_pkg::line_req_t refill;
    dcache_pkg::line_tag_t snoop_tag;
    dcache_pkg::mshr_entry_t push;

    store_align u_store_align (
        .store_req   (store_req),
        .store_write (store_write)
    );

    line_store u_line_store (
        .clock       (clock),
        .reset       (reset),
        .read_addrs  (read_addrs),
        .cache_outs  (cache_outs),
        .store_write (store_write),
        .store_hit   (store_hit),
        .store_done  (store_done),
        .refill      (refill),
        .refill_data (mem_data),
        .eviction    (eviction)
    );

    miss_tracker u_miss_tracker (
        .clock        (clock),
        .reset        (reset),
        .snoop_tag    (snoop_tag),
        .dup_found    (dup_found),
        .push         (push),
        .mem_data_tag (mem_data_tag),
        .refill       (refill)
    );

    mem_port_arbiter u_mem_port_arbiter (
        .read_addrs       (read_addrs),
        .cache_outs       (cache_outs),
        .store_req        (store_req),
        .store_hit        (store_hit),
        .eviction         (eviction),
        .dup_found        (dup_found),
        .snoop_tag        (snoop_tag),
        .mem_req          (mem_req),
        .mem_req_accepted (mem_req_accepted),
        .current_req_tag  (current_req_tag),
        .push             (push),
        .mem_write        (mem_write)
    );

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

    localparam logic [31:0] IMAGE_KEY = 32'h5a3c96e1;
    localparam int WAIT_LIMIT = 200;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_LOAD,
        OP_STORE
    } op_kind_e;

    // Load pair on addr0 and addr1, or a store to addr0
    typedef struct packed {
        op_kind_e kind;
        logic fresh;
        dcache_pkg::addr_t addr0;
        dcache_pkg::addr_t addr1;
        dcache_pkg::mem_size_e size;
        dcache_pkg::word_t data;
    } op_t;

    typedef struct packed {
        dcache_pkg::mem_tag_t mem_tag;
        dcache_pkg::line_tag_t tag;
        int due;
    } pending_t;

    logic clock;
    logic reset;
    dcache_pkg::line_req_t [dcache_pkg::READ_PORTS-1:0] read_addrs;
    dcache_pkg::read_result_t [dcache_pkg::READ_PORTS-1:0] cache_outs;
    dcache_pkg::store_req_t store_req;
    logic store_done;
    dcache_pkg::line_req_t mem_req;
    logic mem_req_accepted;
    dcache_pkg::mem_tag_t current_req_tag;
    dcache_pkg::block_t mem_data;
    dcache_pkg::mem_tag_t mem_data_tag;
    dcache_pkg::writeback_t mem_write;

    logic [31:0] lfsr_state;
    int writeback_count;
    dcache_pkg::block_t mem_image [dcache_pkg::line_tag_t];
    dcache_pkg::block_t ref_data [dcache_pkg::line_tag_t];
    logic ref_dirty [dcache_pkg::line_tag_t];
    pending_t pending [$];
    op_t ops [$];

    dcache_subsystem dut (
        .clock            (clock),
        .reset            (reset),
        .read_addrs       (read_addrs),
        .cache_outs       (cache_outs),
        .store_req        (store_req),
        .store_done       (store_done),
        .mem_req          (mem_req),
        .mem_req_accepted (mem_req_accepted),
        .current_req_tag  (current_req_tag),
        .mem_data         (mem_data),
        .mem_data_tag     (mem_data_tag),
        .mem_write        (mem_write)
    );

    always #5 clock = ~clock;

    // Fibonacci LFSR, taps 32,22,2,1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int draw(int bits);
        int value;
        value = 0;
        for (int i = 0; i < bits; i++) begin
            value = (value << 1) | int'(next_bit());
        end
        return value;
    endfunction

    // Untouched memory holds each word's byte address XOR a key
    function automatic dcache_pkg::block_t image_block(dcache_pkg::line_tag_t tag);
        dcache_pkg::addr_t base;
        base = {tag, 3'b000};
        if (mem_image.exists(tag)) begin
            return mem_image[tag];
        end
        return {(base + 32'd4) ^ IMAGE_KEY, base ^ IMAGE_KEY};
    endfunction

    function automatic dcache_pkg::block_t expected_block(dcache_pkg::line_tag_t tag);
        if (ref_data.exists(tag)) begin
            return ref_data[tag];
        end
        return image_block(tag);
    endfunction

    task automatic stop_run(string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
        assert (got === expected) else begin
            stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic add_op(op_kind_e kind, logic fresh, dcache_pkg::addr_t addr0,
                          dcache_pkg::addr_t addr1, dcache_pkg::mem_size_e size,
                          dcache_pkg::word_t data);
        op_t op;
        op = '{kind: kind, fresh: fresh, addr0: addr0, addr1: addr1, size: size, data: data};
        ops.push_back(op);
    endtask

    // Merge a completed store into the expected line
    task automatic apply_store(op_t op);
        dcache_pkg::line_tag_t tag;
        dcache_pkg::block_t old_block;
        dcache_pkg::block_t new_block;
        int nbytes;
        int base;
        tag = op.addr0[31:dcache_pkg::OFFSET_BITS];
        old_block = expected_block(tag);
        new_block = old_block;
        nbytes = (op.size == dcache_pkg::BYTE) ? 1 : (op.size == dcache_pkg::HALF) ? 2 : 4;
        base = int'(op.addr0[2:0]) & ~(nbytes - 1);
        for (int i = 0; i < nbytes; i++) begin
            new_block[8*(base+i) +: 8] = op.data[8*i +: 8];
        end
        ref_data[tag] = new_block;
        if (new_block != old_block) begin
            ref_dirty[tag] = 1'b1;
        end
    endtask

    task automatic check_writeback();
        dcache_pkg::line_tag_t tag;
        tag = mem_write.tag;
        assert (ref_dirty.exists(tag) && ref_dirty[tag]) else begin
            stop_run($sformatf("Line %h was written back although it is clean", tag));
        end
        check_value("mem_write.data", mem_write.data, ref_data[tag]);
        mem_image[tag] = mem_write.data;
        ref_dirty[tag] = 1'b0;
        writeback_count++;
    endtask

    task automatic expect_request(dcache_pkg::line_tag_t tag, logic is_store);
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(posedge clock);
            if (is_store) begin
                check_value("store_done", 64'(store_done), 64'h0);
            end
            if (mem_req.valid) begin
                check_value("mem_req.tag", 64'(mem_req.tag), 64'(tag));
                return;
            end
        end
        stop_run("Timed out waiting for a memory read request");
    endtask

    task automatic wait_loads(dcache_pkg::line_tag_t tag0, dcache_pkg::line_tag_t tag1);
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(posedge clock);
            if (cache_outs[0].valid && cache_outs[1].valid) begin
                check_value("cache_outs[0].data", cache_outs[0].data, expected_block(tag0));
                check_value("cache_outs[1].data", cache_outs[1].data, expected_block(tag1));
                return;
            end
        end
        stop_run("Timed out waiting for both load ports to hit");
    endtask

    task automatic wait_store(op_t op);
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(posedge clock);
            if (store_done) begin
                apply_store(op);
                return;
            end
        end
        stop_run("Timed out waiting for store_done");
    endtask

    task automatic run_op(op_t op);
        dcache_pkg::line_tag_t tag0;
        dcache_pkg::line_tag_t tag1;
        tag0 = op.addr0[31:dcache_pkg::OFFSET_BITS];
        tag1 = op.addr1[31:dcache_pkg::OFFSET_BITS];
        @(negedge clock);
        read_addrs[0] = '{valid: op.kind == OP_LOAD, tag: tag0};
        read_addrs[1] = '{valid: op.kind == OP_LOAD, tag: tag1};
        store_req = '{valid: op.kind == OP_STORE, addr: op.addr0, data: op.data, size: op.size};
        // First touch of a line must miss, port 0 or the store going first
        if (op.fresh) begin
            expect_request(tag0, op.kind == OP_STORE);
        end
        case (op.kind)
            OP_LOAD: wait_loads(tag0, tag1);
            OP_STORE: wait_store(op);
            default: begin
                for (int i = 0; i < 4; i++) begin
                    @(posedge clock);
                end
            end
        endcase
    endtask

    // Memory with random accept and response delays, answering in request order
    initial begin : memory_model
        int accept_wait;
        int now;
        int due;
        int last_due;
        logic responding;
        dcache_pkg::mem_tag_t next_tag;
        pending_t entry;
        lfsr_state = 32'h156382b1;
        writeback_count = 0;
        mem_req_accepted = 1'b0;
        current_req_tag = 4'd1;
        mem_data = '0;
        mem_data_tag = '0;
        next_tag = 4'd1;
        now = 0;
        last_due = 0;
        responding = 1'b0;
        accept_wait = 1 + draw(2) % 3;
        forever begin
            @(posedge clock);
            now++;
            if (mem_req.valid && mem_req_accepted) begin
                foreach (pending[i]) begin
                    assert (pending[i].tag != mem_req.tag) else begin
                        stop_run($sformatf("Line %h requested again while outstanding",
                                           mem_req.tag));
                    end
                end
                due = now + 1 + draw(2);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                entry = '{mem_tag: current_req_tag, tag: mem_req.tag, due: due};
                pending.push_back(entry);
                next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
                accept_wait = 1 + draw(2) % 3;
            end else if (mem_req.valid && accept_wait > 0) begin
                accept_wait--;
            end
            if (responding) begin
                void'(pending.pop_front());
                responding = 1'b0;
            end
            if (mem_write.valid === 1'b1) begin
                check_writeback();
            end
            @(negedge clock);
            mem_req_accepted = (accept_wait == 0);
            current_req_tag = next_tag;
            mem_data_tag = '0;
            if (pending.size() > 0 && pending[0].due <= now) begin
                mem_data_tag = pending[0].mem_tag;
                mem_data = image_block(pending[0].tag);
                responding = 1'b1;
            end
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        read_addrs = '0;
        store_req = '0;
        // Two absent lines, then hits on both ports with the ports swapped
        add_op(OP_LOAD, 1'b1, 32'h0000_1000, 32'h0000_1008, dcache_pkg::WORD, 32'h0);
        add_op(OP_LOAD, 1'b0, 32'h0000_1008, 32'h0000_1000, dcache_pkg::WORD, 32'h0);
        add_op(OP_STORE, 1'b0, 32'h0000_1005, 32'h0, dcache_pkg::BYTE, 32'h0000_00a5);
        add_op(OP_STORE, 1'b0, 32'h0000_100a, 32'h0, dcache_pkg::HALF, 32'h0000_beef);
        add_op(OP_STORE, 1'b0, 32'h0000_1000, 32'h0, dcache_pkg::WORD, 32'h1234_5678);
        add_op(OP_LOAD, 1'b0, 32'h0000_1000, 32'h0000_1008, dcache_pkg::WORD, 32'h0);
        // Store misses fill the last free lines
        add_op(OP_STORE, 1'b1, 32'h0000_2044, 32'h0, dcache_pkg::WORD, 32'hcafe_f00d);
        add_op(OP_STORE, 1'b1, 32'h0000_3ffe, 32'h0, dcache_pkg::HALF, 32'h0000_1357);
        add_op(OP_LOAD, 1'b0, 32'h0000_2040, 32'h0000_3ff8, dcache_pkg::WORD, 32'h0);
        // Every line is dirty now, so these refills force writebacks
        add_op(OP_LOAD, 1'b1, 32'h8000_0010, 32'h0000_0100, dcache_pkg::WORD, 32'h0);
        add_op(OP_STORE, 1'b0, 32'h8000_0010, 32'h0, dcache_pkg::BYTE, 32'h0000_003c);
        add_op(OP_LOAD, 1'b1, 32'h0000_1238, 32'h0000_1000, dcache_pkg::WORD, 32'h0);
        add_op(OP_IDLE, 1'b0, 32'h0, 32'h0, dcache_pkg::WORD, 32'h0);
        add_op(OP_LOAD, 1'b0, 32'h0000_1000, 32'h0000_1008, dcache_pkg::WORD, 32'h0);
        add_op(OP_LOAD, 1'b0, 32'h0000_2040, 32'h0000_3ff8, dcache_pkg::WORD, 32'h0);
        add_op(OP_LOAD, 1'b0, 32'h8000_0010, 32'h0000_1238, dcache_pkg::WORD, 32'h0);
        for (int i = 0; i < 16; i++) begin
            @(posedge clock);
        end
        @(negedge clock);
        reset = 1'b1;
        foreach (ops[i]) begin
            run_op(ops[i]);
        end
        @(negedge clock);
        read_addrs = '0;
        store_req = '0;
        // Let a late writeback reach the memory model
        for (int i = 0; i < 8; i++) begin
            @(posedge clock);
        end
        if (writeback_count > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_run("No dirty line was ever written back");
        end
    end

endmodule

// ==== sources.f ====
dcache_pkg.sv
store_align.sv
line_store.sv
miss_tracker.sv
mem_port_arbiter.sv
dcache_subsystem.sv
tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dcache
RTL_TOP ?= dcache_subsystem
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass only if the simulation printed the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
